// ==== flist.f ====
hw/ekf_pkg.sv
hw/ekf_wb_regs.sv
hw/ekf_seq_ctrl.sv
hw/b_cache_din_map.sv
hw/b_cache_mem.sv
hw/ekf_bcache_top.sv
tb/ekf_bcache_tb.sv

// ==== hw/b_cache_din_map.sv ====
`default_nettype none

module b_cache_din_map (
  input  wire logic               clk,
  input  wire logic               sys_rst,
  input  wire ekf_pkg::bca_sel_e  bca_sel,
  input  wire ekf_pkg::seq_cnt_t  seq_cnt,
  input  wire ekf_pkg::rsa_word_t fxi_13,
  input  wire ekf_pkg::rsa_word_t fxi_23,
  input  wire ekf_pkg::rsa_word_t gxi_13,
  input  wire ekf_pkg::rsa_word_t gz_11,
  input  wire ekf_pkg::rsa_word_t gz_12,
  input  wire ekf_pkg::rsa_word_t gz_21,
  input  wire ekf_pkg::rsa_word_t gz_22,
  input  wire ekf_pkg::rsa_word_t hz_11,
  input  wire ekf_pkg::rsa_word_t hz_12,
  input  wire ekf_pkg::rsa_word_t hz_21,
  input  wire ekf_pkg::rsa_word_t hz_22,
  input  wire ekf_pkg::rsa_word_t hxi_11,
  input  wire ekf_pkg::rsa_word_t hxi_12,
  input  wire ekf_pkg::rsa_word_t hxi_21,
  input  wire ekf_pkg::rsa_word_t hxi_22,
  input  wire ekf_pkg::rsa_word_t vt_1,
  input  wire ekf_pkg::rsa_word_t vt_2,
  input  wire ekf_pkg::rsa_word_t s_11,
  input  wire ekf_pkg::rsa_word_t s_12,
  input  wire ekf_pkg::rsa_word_t s_21,
  input  wire ekf_pkg::rsa_word_t s_22,
  output ekf_pkg::row_t           b_cache_din,
  output ekf_pkg::rsa_word_t      s_det
);

  ekf_pkg::rsa_word_t s11_q;
  ekf_pkg::rsa_word_t s22_q;
  ekf_pkg::rsa_word_t prod_diag;
  ekf_pkg::rsa_word_t prod_off;
  ekf_pkg::row_t      row_next;

  // lane 0 lands in the low word
  function automatic ekf_pkg::row_t mk_row(input ekf_pkg::rsa_word_t l0,
                                           input ekf_pkg::rsa_word_t l1,
                                           input ekf_pkg::rsa_word_t l2);
    return {ekf_pkg::rsa_word_t'(0), l2, l1, l0};
  endfunction

  always_comb begin
    row_next = '0;
    case (bca_sel)
      ekf_pkg::bca_wr_nl_prd: begin
        case (seq_cnt)
          4'd1:    row_next = mk_row(1, 0, 0);
          4'd2:    row_next = mk_row(0, 1, 0);
          4'd3:    row_next = mk_row(fxi_13, fxi_23, 1);
          default: row_next = '0;
        endcase
      end
      ekf_pkg::bca_wr_nl_new: begin
        case (seq_cnt)
          4'd1:    row_next = mk_row(1, 0, 0);
          4'd3:    row_next = mk_row(gxi_13, 1, 0);
          4'd4:    row_next = mk_row(gz_11, gxi_13, 0);
          4'd5:    row_next = mk_row(gz_12, gz_21, 0);
          4'd6:    row_next = mk_row(0, gz_22, 0);
          default: row_next = '0;
        endcase
      end
      ekf_pkg::bca_wr_nl_upd: begin
        case (seq_cnt)
          4'd1:    row_next = mk_row(hxi_11, 0, 0);
          4'd2:    row_next = mk_row(hxi_12, hxi_21, 0);
          4'd3:    row_next = mk_row(0, hxi_22, 0);
          4'd4:    row_next = mk_row(hz_11, -1, 0);
          4'd5:    row_next = mk_row(hz_12, hz_21, 0);
          4'd6:    row_next = mk_row(vt_1, hz_22, 0);
          4'd7:    row_next = mk_row(vt_2, 0, 0);
          default: row_next = '0;
        endcase
      end
      ekf_pkg::bca_wr_inv: begin
        // adjugate of S+Q, no division
        case (seq_cnt)
          4'd7:    row_next = mk_row(s22_q, 0, 0);
          4'd8:    row_next = mk_row(-s_12, -s_21, 0);
          4'd9:    row_next = mk_row(0, s11_q, 0);
          default: row_next = '0;
        endcase
      end
      default: row_next = '0;
    endcase
  end

  // determinant pipeline over steps 3 to 5
  always_ff @(posedge clk) begin
    if (bca_sel == ekf_pkg::bca_wr_inv) begin
      case (seq_cnt)
        4'd3: s11_q <= s_11 + ekf_pkg::q_11;
        4'd4: begin
          s22_q    <= s_22 + ekf_pkg::q_22;
          prod_off <= s_12 * s_21;
        end
        4'd5: prod_diag <= s11_q * s22_q;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      b_cache_din <= '0;
      s_det       <= '0;
    end else begin
      b_cache_din <= row_next;
      if (bca_sel == ekf_pkg::bca_wr_inv && seq_cnt == 4'd6) begin
        s_det <= prod_diag - prod_off;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/b_cache_mem.sv ====
`default_nettype none

module b_cache_mem (
  input  wire logic                          clk,
  input  wire logic                          cache_we,
  input  wire ekf_pkg::cache_addr_t          cache_waddr,
  input  wire ekf_pkg::row_t                 b_cache_din,
  input  wire ekf_pkg::cache_addr_t          cache_raddr,
  input  wire logic [$clog2(ekf_pkg::lanes)-1:0] cache_rlane,
  output ekf_pkg::rsa_word_t                 cache_rdata
);

  ekf_pkg::row_t mem [ekf_pkg::cache_depth];

  // whole row in, one lane out
  always_ff @(posedge clk) begin
    if (cache_we) begin
      mem[cache_waddr] <= b_cache_din;
    end
    cache_rdata <= mem[cache_raddr][cache_rlane*ekf_pkg::rsa_dw +: ekf_pkg::rsa_dw];
  end

endmodule

`default_nettype wire

// ==== hw/ekf_bcache_top.sv ====
`default_nettype none

module ekf_bcache_top (
  input  wire logic               clk,
  input  wire logic               sys_rst,
  input  wire logic               wb_cyc,
  input  wire logic               wb_stb,
  input  wire logic               wb_we,
  input  wire ekf_pkg::wb_addr_t  wb_adr,
  input  wire ekf_pkg::rsa_word_t wb_dat_w,
  output ekf_pkg::rsa_word_t      wb_dat_r,
  output logic                    wb_ack
);

  logic                                 cmd_valid;
  ekf_pkg::bca_sel_e                    cmd_sel;
  logic                                 busy;
  ekf_pkg::bca_sel_e                    bca_sel;
  ekf_pkg::seq_cnt_t                    seq_cnt;
  logic                                 cache_we;
  ekf_pkg::cache_addr_t                 cache_waddr;
  ekf_pkg::cache_addr_t                 cache_raddr;
  logic [$clog2(ekf_pkg::lanes)-1:0]    cache_rlane;
  ekf_pkg::rsa_word_t                   cache_rdata;
  ekf_pkg::row_t                        b_cache_din;
  ekf_pkg::rsa_word_t                   s_det;
  ekf_pkg::rsa_word_t                   fxi_13, fxi_23, gxi_13;
  ekf_pkg::rsa_word_t                   gz_11, gz_12, gz_21, gz_22;
  ekf_pkg::rsa_word_t                   hz_11, hz_12, hz_21, hz_22;
  ekf_pkg::rsa_word_t                   hxi_11, hxi_12, hxi_21, hxi_22;
  ekf_pkg::rsa_word_t                   vt_1, vt_2;
  ekf_pkg::rsa_word_t                   s_11, s_12, s_21, s_22;

  ekf_wb_regs ekf_wb_regs_inst (
    .clk, .sys_rst,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .busy, .s_det, .cache_rdata, .cmd_valid, .cmd_sel,
    .fxi_13, .fxi_23, .gxi_13, .gz_11, .gz_12, .gz_21, .gz_22,
    .hz_11, .hz_12, .hz_21, .hz_22, .hxi_11, .hxi_12, .hxi_21, .hxi_22,
    .vt_1, .vt_2, .s_11, .s_12, .s_21, .s_22,
    .cache_raddr, .cache_rlane
  );

  ekf_seq_ctrl ekf_seq_ctrl_inst (
    .clk, .sys_rst, .cmd_valid, .cmd_sel,
    .busy, .bca_sel, .seq_cnt, .cache_we, .cache_waddr
  );

  b_cache_din_map b_cache_din_map_inst (
    .clk, .sys_rst, .bca_sel, .seq_cnt,
    .fxi_13, .fxi_23, .gxi_13, .gz_11, .gz_12, .gz_21, .gz_22,
    .hz_11, .hz_12, .hz_21, .hz_22, .hxi_11, .hxi_12, .hxi_21, .hxi_22,
    .vt_1, .vt_2, .s_11, .s_12, .s_21, .s_22,
    .b_cache_din, .s_det
  );

  b_cache_mem b_cache_mem_inst (
    .clk, .cache_we, .cache_waddr, .b_cache_din,
    .cache_raddr, .cache_rlane, .cache_rdata
  );

endmodule

`default_nettype wire

// ==== hw/ekf_pkg.sv ====
`default_nettype none

package ekf_pkg;

  localparam int rsa_dw      = 32;
  localparam int lanes       = 4;
  localparam int cache_depth = 32;
  localparam int num_terms   = 21;

  typedef logic signed [rsa_dw-1:0]       rsa_word_t;
  typedef logic        [lanes*rsa_dw-1:0] row_t;
  typedef logic        [3:0]              seq_cnt_t;
  typedef logic        [4:0]              cache_addr_t;
  typedef logic        [7:0]              wb_addr_t;

  typedef enum logic [3:0] {
    bca_idle      = 4'b0000,
    bca_wr_inv    = 4'b1010,
    bca_wr_nl_prd = 4'b1101,
    bca_wr_nl_new = 4'b1110,
    bca_wr_nl_upd = 4'b1111
  } bca_sel_e;

  // process noise diagonal
  localparam rsa_word_t q_11 = 1;
  localparam rsa_word_t q_22 = 1;

  // row schedules per mode
  localparam seq_cnt_t    prd_first = 4'd1;
  localparam seq_cnt_t    prd_last  = 4'd3;
  localparam cache_addr_t prd_base  = 5'd0;
  localparam seq_cnt_t    new_first = 4'd1;
  localparam seq_cnt_t    new_last  = 4'd6;
  localparam cache_addr_t new_base  = 5'd4;
  localparam seq_cnt_t    upd_first = 4'd1;
  localparam seq_cnt_t    upd_last  = 4'd7;
  localparam cache_addr_t upd_base  = 5'd12;
  localparam seq_cnt_t    inv_first = 4'd7;
  localparam seq_cnt_t    inv_last  = 4'd9;
  localparam cache_addr_t inv_base  = 5'd20;

  // host register map, word addresses
  localparam wb_addr_t reg_cmd        = 8'h00;
  localparam wb_addr_t reg_status     = 8'h01;
  localparam wb_addr_t reg_term_base  = 8'h02;
  localparam wb_addr_t reg_term_last  = 8'h16;
  localparam wb_addr_t reg_det        = 8'h17;
  localparam wb_addr_t reg_cache_base = 8'h80;

endpackage

`default_nettype wire

// ==== hw/ekf_seq_ctrl.sv ====
`default_nettype none

module ekf_seq_ctrl (
  input  wire logic                 clk,
  input  wire logic                 sys_rst,
  input  wire logic                 cmd_valid,
  input  wire ekf_pkg::bca_sel_e    cmd_sel,
  output logic                      busy,
  output ekf_pkg::bca_sel_e         bca_sel,
  output ekf_pkg::seq_cnt_t         seq_cnt,
  output logic                      cache_we,
  output ekf_pkg::cache_addr_t      cache_waddr
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } ekf_seq_ctrl_state_e;

  ekf_seq_ctrl_state_e  state;
  ekf_pkg::bca_sel_e    mode_q;
  ekf_pkg::seq_cnt_t    cnt;
  ekf_pkg::seq_cnt_t    first_step;
  ekf_pkg::seq_cnt_t    last_step;
  ekf_pkg::cache_addr_t base_row;

  // schedule lookup for the active mode
  always_comb begin
    case (mode_q)
      ekf_pkg::bca_wr_nl_new: begin
        first_step = ekf_pkg::new_first;
        last_step  = ekf_pkg::new_last;
        base_row   = ekf_pkg::new_base;
      end
      ekf_pkg::bca_wr_nl_upd: begin
        first_step = ekf_pkg::upd_first;
        last_step  = ekf_pkg::upd_last;
        base_row   = ekf_pkg::upd_base;
      end
      ekf_pkg::bca_wr_inv: begin
        first_step = ekf_pkg::inv_first;
        last_step  = ekf_pkg::inv_last;
        base_row   = ekf_pkg::inv_base;
      end
      default: begin
        first_step = ekf_pkg::prd_first;
        last_step  = ekf_pkg::prd_last;
        base_row   = ekf_pkg::prd_base;
      end
    endcase
  end

  assign busy    = (state != st_idle);
  assign bca_sel = (state == st_run) ? mode_q : ekf_pkg::bca_idle;
  assign seq_cnt = cnt;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state       <= st_idle;
      mode_q      <= ekf_pkg::bca_idle;
      cnt         <= '0;
      cache_we    <= 1'b0;
      cache_waddr <= '0;
    end else begin
      // one cycle behind the step, matching the mapper register
      cache_we    <= (state == st_run) && (cnt >= first_step);
      cache_waddr <= base_row + ekf_pkg::cache_addr_t'(cnt - first_step);
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            mode_q <= cmd_sel;
            cnt    <= 4'd1;
            state  <= st_run;
          end
        end
        st_run: begin
          if (cnt == last_step) begin
            cnt   <= '0;
            state <= st_drain;
          end else begin
            cnt <= cnt + 4'd1;
          end
        end
        st_drain: begin
          // last row is written this cycle
          mode_q <= ekf_pkg::bca_idle;
          state  <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/ekf_wb_regs.sv ====
`default_nettype none

module ekf_wb_regs (
  input  wire logic                                clk,
  input  wire logic                                sys_rst,
  input  wire logic                                wb_cyc,
  input  wire logic                                wb_stb,
  input  wire logic                                wb_we,
  input  wire ekf_pkg::wb_addr_t                   wb_adr,
  input  wire ekf_pkg::rsa_word_t                  wb_dat_w,
  output ekf_pkg::rsa_word_t                       wb_dat_r,
  output logic                                     wb_ack,
  input  wire logic                                busy,
  input  wire ekf_pkg::rsa_word_t                  s_det,
  input  wire ekf_pkg::rsa_word_t                  cache_rdata,
  output logic                                     cmd_valid,
  output ekf_pkg::bca_sel_e                        cmd_sel,
  output ekf_pkg::rsa_word_t                       fxi_13,
  output ekf_pkg::rsa_word_t                       fxi_23,
  output ekf_pkg::rsa_word_t                       gxi_13,
  output ekf_pkg::rsa_word_t                       gz_11,
  output ekf_pkg::rsa_word_t                       gz_12,
  output ekf_pkg::rsa_word_t                       gz_21,
  output ekf_pkg::rsa_word_t                       gz_22,
  output ekf_pkg::rsa_word_t                       hz_11,
  output ekf_pkg::rsa_word_t                       hz_12,
  output ekf_pkg::rsa_word_t                       hz_21,
  output ekf_pkg::rsa_word_t                       hz_22,
  output ekf_pkg::rsa_word_t                       hxi_11,
  output ekf_pkg::rsa_word_t                       hxi_12,
  output ekf_pkg::rsa_word_t                       hxi_21,
  output ekf_pkg::rsa_word_t                       hxi_22,
  output ekf_pkg::rsa_word_t                       vt_1,
  output ekf_pkg::rsa_word_t                       vt_2,
  output ekf_pkg::rsa_word_t                       s_11,
  output ekf_pkg::rsa_word_t                       s_12,
  output ekf_pkg::rsa_word_t                       s_21,
  output ekf_pkg::rsa_word_t                       s_22,
  output ekf_pkg::cache_addr_t                     cache_raddr,
  output logic [$clog2(ekf_pkg::lanes)-1:0]        cache_rlane
);

  localparam int lane_bits = $clog2(ekf_pkg::lanes);

  ekf_pkg::rsa_word_t term_q [ekf_pkg::num_terms];
  ekf_pkg::rsa_word_t rd_data;
  ekf_pkg::wb_addr_t  cache_off;
  logic               req_start;
  logic               req_q;
  logic               hit_term;
  logic               hit_cache;
  logic               cmd_legal;
  logic [4:0]         term_idx;

  // new request only when nothing is in flight
  assign req_start = wb_cyc && wb_stb && !req_q;

  assign hit_term  = (wb_adr >= ekf_pkg::reg_term_base) && (wb_adr <= ekf_pkg::reg_term_last);
  assign hit_cache = (wb_adr >= ekf_pkg::reg_cache_base);
  assign term_idx  = 5'(wb_adr - ekf_pkg::reg_term_base);

  // host address is held until ack, so the cache read lines up with req_q
  assign cache_off   = wb_adr - ekf_pkg::reg_cache_base;
  assign cache_raddr = ekf_pkg::cache_addr_t'(cache_off >> lane_bits);
  assign cache_rlane = cache_off[lane_bits-1:0];

  always_comb begin
    case (wb_dat_w)
      {28'b0, ekf_pkg::bca_wr_inv},
      {28'b0, ekf_pkg::bca_wr_nl_prd},
      {28'b0, ekf_pkg::bca_wr_nl_new},
      {28'b0, ekf_pkg::bca_wr_nl_upd}: cmd_legal = 1'b1;
      default:                          cmd_legal = 1'b0;
    endcase
  end

  always_comb begin
    rd_data = '0;
    if (hit_cache) begin
      rd_data = cache_rdata;
    end else if (hit_term) begin
      rd_data = term_q[term_idx];
    end else if (wb_adr == ekf_pkg::reg_cmd) begin
      rd_data = {28'b0, cmd_sel};
    end else if (wb_adr == ekf_pkg::reg_status) begin
      rd_data = {31'b0, busy};
    end else if (wb_adr == ekf_pkg::reg_det) begin
      rd_data = s_det;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      req_q     <= 1'b0;
      wb_ack    <= 1'b0;
      cmd_valid <= 1'b0;
      cmd_sel   <= ekf_pkg::bca_idle;
      for (int i = 0; i < ekf_pkg::num_terms; i++) begin
        term_q[i] <= '0;
      end
    end else begin
      req_q     <= req_start;
      wb_ack    <= req_q;
      cmd_valid <= 1'b0;
      if (req_q && wb_we) begin
        if (hit_term) begin
          term_q[term_idx] <= wb_dat_w;
        end
        // commands dropped while a fill is running
        if (wb_adr == ekf_pkg::reg_cmd && cmd_legal && !busy) begin
          cmd_valid <= 1'b1;
          cmd_sel   <= ekf_pkg::bca_sel_e'(wb_dat_w[3:0]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_q) begin
      wb_dat_r <= rd_data;
    end
  end

  assign fxi_13 = term_q[0];
  assign fxi_23 = term_q[1];
  assign gxi_13 = term_q[2];
  assign gz_11  = term_q[3];
  assign gz_12  = term_q[4];
  assign gz_21  = term_q[5];
  assign gz_22  = term_q[6];
  assign hz_11  = term_q[7];
  assign hz_12  = term_q[8];
  assign hz_21  = term_q[9];
  assign hz_22  = term_q[10];
  assign hxi_11 = term_q[11];
  assign hxi_12 = term_q[12];
  assign hxi_21 = term_q[13];
  assign hxi_22 = term_q[14];
  assign vt_1   = term_q[15];
  assign vt_2   = term_q[16];
  assign s_11   = term_q[17];
  assign s_12   = term_q[18];
  assign s_21   = term_q[19];
  assign s_22   = term_q[20];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module ekf_bcache_tb -f flist.f \
  -o ekf_bcache_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ekf_bcache_sim > sim.log 2>&1 \
  || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0

// ==== tb/ekf_bcache_tb.sv ====
`default_nettype none

module ekf_bcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period      = 8;
  localparam int watchdog_cycles = 4000;

  // register map and schedules as seen from the host
  localparam int reg_cmd    = 'h00;
  localparam int reg_status = 'h01;
  localparam int term_base  = 'h02;
  localparam int num_terms  = 21;
  localparam int reg_det    = 'h17;
  localparam int cache_base = 'h80;
  localparam logic [31:0] cmd_inv = 32'ha;
  localparam logic [31:0] cmd_prd = 32'hd;
  localparam logic [31:0] cmd_new = 32'he;
  localparam logic [31:0] cmd_upd = 32'hf;
  localparam int prd_first = 1;
  localparam int prd_last  = 3;
  localparam int prd_base  = 0;
  localparam int new_first = 1;
  localparam int new_last  = 6;
  localparam int new_base  = 4;
  localparam int upd_first = 1;
  localparam int upd_last  = 7;
  localparam int upd_base  = 12;
  localparam int inv_first = 7;
  localparam int inv_last  = 9;
  localparam int inv_base  = 20;

  // term register order
  localparam int i_fxi_13 = 0;
  localparam int i_fxi_23 = 1;
  localparam int i_gxi_13 = 2;
  localparam int i_gz_11  = 3;
  localparam int i_gz_12  = 4;
  localparam int i_gz_21  = 5;
  localparam int i_gz_22  = 6;
  localparam int i_hz_11  = 7;
  localparam int i_hz_12  = 8;
  localparam int i_hz_21  = 9;
  localparam int i_hz_22  = 10;
  localparam int i_hxi_11 = 11;
  localparam int i_hxi_12 = 12;
  localparam int i_hxi_21 = 13;
  localparam int i_hxi_22 = 14;
  localparam int i_vt_1   = 15;
  localparam int i_vt_2   = 16;
  localparam int i_s_11   = 17;
  localparam int i_s_12   = 18;
  localparam int i_s_21   = 19;
  localparam int i_s_22   = 20;

  logic        clk;
  logic        sys_rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [31:0] terms [num_terms];
  logic [31:0] exp_cache [32][4];
  logic [31:0] exp_det;
  logic [31:0] lcg_state;
  int          errors;
  int          requests;
  int          ack_seen;

  ekf_bcache_top ekf_bcache_top_inst (
    .clk, .sys_rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  // every ack pulse is counted once
  always @(posedge clk) begin
    if (wb_ack) begin
      ack_seen++;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the ack edge
  task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int cycles;
    cycles   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = 8'(adr);
    wb_dat_w = wdat;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!wb_ack);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    requests++;
    assert (cycles == 2) else begin
      $display("Fail at %0t ns: ack after %0d cycles at address 0x%02h", $time, cycles, adr);
      errors++;
    end
  endtask

  task automatic wb_write(input int adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input int adr, output logic [31:0] rdat);
    wb_access(1'b0, adr, 32'h0, rdat);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int          tries;
    tries = 0;
    do begin
      wb_read(reg_status, status);
      tries++;
    end while (status[0] && tries < 40);
    assert (!status[0]) else begin
      $display("busy did not clear after a fill command");
      errors++;
    end
  endtask

  task automatic load_terms(input int lo, input int hi);
    for (int i = lo; i <= hi; i++) begin
      terms[i] = lcg_next();
      wb_write(term_base + i, terms[i]);
    end
  endtask

  task automatic put_row(input int base, input int first, input int step,
                         input logic [31:0] l0, input logic [31:0] l1, input logic [31:0] l2);
    exp_cache[base + step - first][0] = l0;
    exp_cache[base + step - first][1] = l1;
    exp_cache[base + step - first][2] = l2;
    exp_cache[base + step - first][3] = 32'h0;
  endtask

  task automatic predict_rows();
    put_row(prd_base, prd_first, 1, 1, 0, 0);
    put_row(prd_base, prd_first, 2, 0, 1, 0);
    put_row(prd_base, prd_first, 3, terms[i_fxi_13], terms[i_fxi_23], 1);
  endtask

  task automatic landmark_rows();
    put_row(new_base, new_first, 1, 1, 0, 0);
    put_row(new_base, new_first, 2, 0, 0, 0);
    put_row(new_base, new_first, 3, terms[i_gxi_13], 1, 0);
    put_row(new_base, new_first, 4, terms[i_gz_11], terms[i_gxi_13], 0);
    put_row(new_base, new_first, 5, terms[i_gz_12], terms[i_gz_21], 0);
    put_row(new_base, new_first, 6, 0, terms[i_gz_22], 0);
  endtask

  task automatic update_rows();
    put_row(upd_base, upd_first, 1, terms[i_hxi_11], 0, 0);
    put_row(upd_base, upd_first, 2, terms[i_hxi_12], terms[i_hxi_21], 0);
    put_row(upd_base, upd_first, 3, 0, terms[i_hxi_22], 0);
    put_row(upd_base, upd_first, 4, terms[i_hz_11], 32'hffff_ffff, 0);
    put_row(upd_base, upd_first, 5, terms[i_hz_12], terms[i_hz_21], 0);
    put_row(upd_base, upd_first, 6, terms[i_vt_1], terms[i_hz_22], 0);
    put_row(upd_base, upd_first, 7, terms[i_vt_2], 0, 0);
  endtask

  task automatic inverse_rows();
    logic [31:0] a;
    logic [31:0] d;
    a = terms[i_s_11] + 32'd1;
    d = terms[i_s_22] + 32'd1;
    put_row(inv_base, inv_first, 7, d, 0, 0);
    put_row(inv_base, inv_first, 8, -terms[i_s_12], -terms[i_s_21], 0);
    put_row(inv_base, inv_first, 9, 0, a, 0);
    exp_det = a * d - terms[i_s_12] * terms[i_s_21];
  endtask

  task automatic check_rows(input int base, input int first, input int last);
    logic [31:0] got;
    int          row;
    for (int step = first; step <= last; step++) begin
      row = base + step - first;
      for (int lane = 0; lane < 4; lane++) begin
        wb_read(cache_base + row * 4 + lane, got);
        check_word(got, exp_cache[row][lane], $sformatf("cache row %0d lane %0d", row, lane));
      end
    end
  endtask

  initial begin
    logic [31:0] rdat;
    errors    = 0;
    requests  = 0;
    ack_seen  = 0;
    lcg_state = 32'd50630;
    sys_rst   = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = 8'h0;
    wb_dat_w  = 32'h0;
    repeat (4) @(posedge clk);
    #1;
    sys_rst = 1'b0;

    // state after reset
    check_word(32'(wb_ack), 32'h0, "ack after reset");
    wb_read(reg_status, rdat);
    check_word(rdat, 32'h0, "status after reset");
    for (int i = 0; i < num_terms; i++) begin
      wb_read(term_base + i, rdat);
      check_word(rdat, 32'h0, $sformatf("term %0d after reset", i));
    end
    wb_read(reg_det, rdat);
    check_word(rdat, 32'h0, "determinant after reset");

    // term registers, read-only and unmapped addresses, illegal command
    load_terms(0, num_terms - 1);
    wb_write(reg_status, 32'h1);
    wb_write(reg_det, 32'h1234);
    for (int i = 0; i < num_terms; i++) begin
      wb_read(term_base + i, rdat);
      check_word(rdat, terms[i], $sformatf("term %0d readback", i));
    end
    wb_read(reg_det, rdat);
    check_word(rdat, 32'h0, "determinant after host write");
    wb_read('h7f, rdat);
    check_word(rdat, 32'h0, "unmapped address");
    wb_write(reg_cmd, 32'h3);
    wb_read(reg_status, rdat);
    check_word(rdat, 32'h0, "status after illegal command");

    // predict, busy must show right after the command
    predict_rows();
    wb_write(reg_cmd, cmd_prd);
    wb_read(reg_status, rdat);
    check_word(rdat, 32'h1, "status during predict");
    wait_idle();
    check_rows(prd_base, prd_first, prd_last);

    landmark_rows();
    wb_write(reg_cmd, cmd_new);
    wait_idle();
    check_rows(new_base, new_first, new_last);

    update_rows();
    wb_write(reg_cmd, cmd_upd);
    wait_idle();
    check_rows(upd_base, upd_first, upd_last);

    load_terms(i_s_11, i_s_22);
    inverse_rows();
    wb_write(reg_cmd, cmd_inv);
    wait_idle();
    check_rows(inv_base, inv_first, inv_last);
    wb_read(reg_det, rdat);
    check_word(rdat, exp_det, "determinant");

    // predict issued while update runs must be dropped
    load_terms(i_fxi_13, i_fxi_23);
    load_terms(i_hz_11, i_vt_2);
    update_rows();
    wb_write(reg_cmd, cmd_upd);
    wb_write(reg_cmd, cmd_prd);
    wait_idle();
    check_rows(prd_base, prd_first, prd_last);
    check_rows(upd_base, upd_first, upd_last);

    repeat (2) @(posedge clk);
    #1;
    assert (ack_seen == requests) else begin
      $display("Fail at %0t ns: saw %0d ack pulses for %0d requests", $time, ack_seen,
               requests);
      errors++;
    end
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
